//--- verilog/soc_bus_pkg.sv
// Bus definitions for the system controller
// Wishbone and CSR widths, region codes and the decoded address word
package soc_bus_pkg;

	// ----------------------------------------
	// Wishbone
	// ----------------------------------------
	localparam int WB_ADDR_W = 32;
	localparam int WB_DATA_W = 32;

	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_DATA_W/8-1:0] wb_sel_t;

	// Top address bits pick the slave region
	localparam int REGION_W = 3;
	localparam logic [REGION_W-1:0] REGION_RAM = 3'b000;
	localparam logic [REGION_W-1:0] REGION_CSR = 3'b100;

	// Same word seen raw by the slaves, split by the decoder
	typedef union packed {
		logic [WB_ADDR_W-1:0] raw;
		struct packed {
			logic [REGION_W-1:0] region;
			logic [WB_ADDR_W-REGION_W-1:0] offset;
		} fld;
	} wb_addr_u;

	// Returned by regions with no device behind them
	localparam wb_data_t ABSENT_PATTERN = 32'habadface;

	// ----------------------------------------
	// CSR bus, word addressed
	// ----------------------------------------
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = 10;
	localparam int CSR_ADDR_W = CSR_BANK_W + CSR_REG_W;

endpackage

//--- verilog/soc_ctrl_pkg.sv
// System controller definitions
// Register map, system ID and reset and LED timing defaults
package soc_ctrl_pkg;

	// Bank of the system controller on the CSR bus
	localparam logic [soc_bus_pkg::CSR_BANK_W-1:0] SYSCTL_BANK = 4'd1;

	// Register indexes inside the bank
	localparam logic [soc_bus_pkg::CSR_REG_W-1:0] REG_GPIO_IN = 10'd0;
	localparam logic [soc_bus_pkg::CSR_REG_W-1:0] REG_GPIO_OUT = 10'd1;
	localparam logic [soc_bus_pkg::CSR_REG_W-1:0] REG_SYSTEM_ID = 10'd2;
	localparam logic [soc_bus_pkg::CSR_REG_W-1:0] REG_HARD_RESET = 10'd3;

	// "MONE"
	localparam logic [31:0] SYSTEM_ID = 32'h4d4f4e45;

	localparam int GPIO_IN_W = 4;
	localparam int GPIO_OUT_W = 2;

	// Timing defaults, in sys_clk cycles
	// Peripheral hold must stay below the debounce time
	localparam int DEBOUNCE_CYCLES_DEF = 16;
	localparam int PERIPH_HOLD_CYCLES_DEF = 6;
	localparam int LED_HOLD_CYCLES_DEF = 32;

endpackage

//--- verilog/soc_ifs.sv
// Bus interfaces inside the system controller
// Point-to-point Wishbone classic and the shared CSR bus
`timescale 1ns/1ps

interface wb_if;
	import soc_bus_pkg::*;

	wb_addr_u adr;
	wb_data_t dat_w;
	wb_data_t dat_r;
	wb_sel_t sel;
	logic we;
	logic cyc;
	logic stb;
	logic ack;

	// Decoder side
	modport master (output adr, dat_w, sel, we, cyc, stb, input dat_r, ack);
	// Slave answers with data and a one-cycle ack
	modport slave (input adr, dat_w, sel, we, cyc, stb, output dat_r, ack);
endinterface

interface csr_if;
	import soc_bus_pkg::*;

	logic [CSR_ADDR_W-1:0] adr;
	logic we;
	wb_data_t dat_w;
	// Zero from a slave whose bank is not addressed
	wb_data_t dat_r;

	modport bridge (output adr, we, dat_w, input dat_r);
	modport slave (input adr, we, dat_w, output dat_r);
endinterface

//--- verilog/reset_ctrl.sv
// Reset conditioner
// Synchronizes and debounces reset, releases peripherals ahead of the system
`timescale 1ns/1ps

module reset_ctrl #(
	parameter int DEBOUNCE_CYCLES = soc_ctrl_pkg::DEBOUNCE_CYCLES_DEF,
	parameter int PERIPH_HOLD_CYCLES = soc_ctrl_pkg::PERIPH_HOLD_CYCLES_DEF
) (
	input  logic sys_clk,
	input  logic reset_i,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic periph_rst_n_o
);

	localparam int DEB_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int HOLD_W = $clog2(PERIPH_HOLD_CYCLES + 1);

	logic rst_meta;
	logic rst_sync;
	logic rst_req;
	logic [DEB_W-1:0] deb_cnt;
	logic [HOLD_W-1:0] hold_cnt;

	// Two-flop synchronizer on the external reset
	always_ff @(posedge sys_clk) begin
		rst_meta <= reset_i;
		rst_sync <= rst_meta;
	end

	// Either source restarts both counters
	assign rst_req = rst_sync | hard_reset_i;

	// ----------------------------------------
	// System reset debounce
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req)
			deb_cnt <= DEB_W'(DEBOUNCE_CYCLES);
		else if (deb_cnt != '0)
			deb_cnt <= deb_cnt - 1'b1;
		sys_rst_o <= rst_req | (deb_cnt != '0);
	end

	// ----------------------------------------
	// Peripheral reset, shorter hold
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req)
			hold_cnt <= HOLD_W'(PERIPH_HOLD_CYCLES);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
		periph_rst_n_o <= ~rst_req & (hold_cnt == '0);
	end

	// Peripherals must be out of reset before the system starts
	assert property (@(posedge sys_clk) $fell(sys_rst_o) |-> periph_rst_n_o)
		else $error("reset_ctrl: system reset released before peripheral reset");

endmodule

//--- verilog/wb_decoder.sv
// Wishbone address decoder
// Routes requests to RAM or CSR bridge, answers absent regions itself
`timescale 1ns/1ps

module wb_decoder (
	input  logic sys_clk,
	input  logic sys_rst_i,
	input  soc_bus_pkg::wb_addr_u adr_i,
	input  soc_bus_pkg::wb_data_t dat_i,
	input  soc_bus_pkg::wb_sel_t sel_i,
	input  logic we_i,
	input  logic cyc_i,
	input  logic stb_i,
	output soc_bus_pkg::wb_data_t dat_o,
	output logic ack_o,
	wb_if.master ram_bus,
	wb_if.master csr_bus
);
	import soc_bus_pkg::*;

	logic req;
	logic hit_ram;
	logic hit_csr;
	logic absent_ack;

	// Requests are held off while the system is in reset
	assign req = cyc_i & stb_i & ~sys_rst_i;

	assign hit_ram = adr_i.fld.region == REGION_RAM;
	assign hit_csr = adr_i.fld.region == REGION_CSR;

	// ----------------------------------------
	// Request fan-out
	// ----------------------------------------
	assign ram_bus.adr = adr_i;
	assign ram_bus.dat_w = dat_i;
	assign ram_bus.sel = sel_i;
	assign ram_bus.we = we_i;
	assign ram_bus.cyc = cyc_i;
	assign ram_bus.stb = req & hit_ram;

	assign csr_bus.adr = adr_i;
	assign csr_bus.dat_w = dat_i;
	assign csr_bus.sel = sel_i;
	assign csr_bus.we = we_i;
	assign csr_bus.cyc = cyc_i;
	assign csr_bus.stb = req & hit_csr;

	// ----------------------------------------
	// Response mux
	// ----------------------------------------
	// No device, so ack in the same cycle
	assign absent_ack = req & ~hit_ram & ~hit_csr;

	assign ack_o = ram_bus.ack | csr_bus.ack | absent_ack;

	// Address is stable for the whole access
	always_comb begin
		if (hit_ram)
			dat_o = ram_bus.dat_r;
		else if (hit_csr)
			dat_o = csr_bus.dat_r;
		else
			dat_o = ABSENT_PATTERN;
	end

	// One access in flight, so responses never overlap
	assert property (@(posedge sys_clk) $onehot0({ram_bus.ack, csr_bus.ack, absent_ack}))
		else $error("wb_decoder: more than one slave acknowledged");

	// A slave ack must land inside the master's request
	assert property (@(posedge sys_clk) ack_o |-> (cyc_i && stb_i))
		else $error("wb_decoder: ack without an active request");

endmodule

//--- verilog/scratch_ram.sv
// On-chip scratch RAM
// Word memory with byte-lane writes and a one-cycle Wishbone ack
`timescale 1ns/1ps

module scratch_ram #(
	parameter int RAM_ADDR_W = 8
) (
	input logic sys_clk,
	wb_if.slave bus
);
	import soc_bus_pkg::*;

	wb_data_t mem [2**RAM_ADDR_W];
	logic [RAM_ADDR_W-1:0] word_idx;
	logic access;

	// Low word address bits only, so the region wraps
	assign word_idx = bus.adr.raw[RAM_ADDR_W+1:2];
	assign access = bus.cyc & bus.stb;

	always_ff @(posedge sys_clk) begin
		// Write once per access, not again in the ack cycle
		if (access & bus.we & ~bus.ack) begin
			for (int i = 0; i < WB_DATA_W / 8; i++) begin
				if (bus.sel[i])
					mem[word_idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
			end
		end
		// Registered read, old data on a write
		bus.dat_r <= mem[word_idx];
		// Single ack pulse, even if stb stays up
		bus.ack <= access & ~bus.ack;
	end

endmodule

//--- verilog/csr_bridge.sv
// Wishbone to CSR bridge
// Turns each Wishbone access into a single CSR cycle, ack two cycles later
`timescale 1ns/1ps

module csr_bridge (
	input logic sys_clk,
	input logic sys_rst_i,
	wb_if.slave bus,
	csr_if.bridge csr
);
	import soc_bus_pkg::*;

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_ACCESS = 2'd1;
	localparam logic [1:0] ST_ACK = 2'd2;

	logic [1:0] state;

	// ----------------------------------------
	// Sequencer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			csr.we <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (bus.cyc & bus.stb) begin
						state <= ST_ACCESS;
						csr.we <= bus.we;
					end
				end
				// Write strobe lasts this cycle only
				ST_ACCESS: begin
					state <= ST_ACK;
					csr.we <= 1'b0;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Address and data follow the bus while idle
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE) begin
			csr.adr <= bus.adr.raw[CSR_ADDR_W+1:2];
			csr.dat_w <= bus.dat_w;
		end
		// Capture the OR-combined read data
		if (state == ST_ACCESS)
			bus.dat_r <= csr.dat_r;
	end

	assign bus.ack = state == ST_ACK;

	assert property (@(posedge sys_clk) csr.we |=> !csr.we)
		else $error("csr_bridge: CSR write strobe longer than one cycle");

endmodule

//--- verilog/sys_ctrl.sv
// System controller CSR bank
// GPIO, system ID, hard-reset trigger and the receive-activity LED
`timescale 1ns/1ps

module sys_ctrl #(
	parameter int LED_HOLD_CYCLES = soc_ctrl_pkg::LED_HOLD_CYCLES_DEF
) (
	input  logic sys_clk,
	input  logic sys_rst_i,
	csr_if.slave csr,
	input  logic [soc_ctrl_pkg::GPIO_IN_W-1:0] gpio_i,
	input  logic uart_rxd_i,
	output logic [soc_ctrl_pkg::GPIO_OUT_W:0] led_o,
	output logic hard_reset_o
);
	import soc_bus_pkg::*;
	import soc_ctrl_pkg::*;

	localparam int LED_W = $clog2(LED_HOLD_CYCLES + 1);

	logic [GPIO_IN_W-1:0] gpio_meta;
	logic [GPIO_IN_W-1:0] gpio_sync;
	logic [GPIO_OUT_W-1:0] gpio_out;
	logic bank_sel;
	logic [CSR_REG_W-1:0] reg_idx;
	logic wr_en;
	logic rxd_q;
	logic [LED_W-1:0] rx_cnt;

	// ----------------------------------------
	// CSR decode
	// ----------------------------------------
	assign bank_sel = csr.adr[CSR_ADDR_W-1 -: CSR_BANK_W] == SYSCTL_BANK;
	assign reg_idx = csr.adr[CSR_REG_W-1:0];
	assign wr_en = csr.we & bank_sel;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			// Any data value triggers it
			hard_reset_o <= wr_en & (reg_idx == REG_HARD_RESET);
			if (wr_en & (reg_idx == REG_GPIO_OUT))
				gpio_out <= csr.dat_w[GPIO_OUT_W-1:0];
		end
	end

	// Other banks see zero from here
	always_comb begin
		csr.dat_r = '0;
		if (bank_sel) begin
			case (reg_idx)
				REG_GPIO_IN: csr.dat_r = WB_DATA_W'(gpio_sync);
				REG_GPIO_OUT: csr.dat_r = WB_DATA_W'(gpio_out);
				REG_SYSTEM_ID: csr.dat_r = SYSTEM_ID;
				default: csr.dat_r = '0;
			endcase
		end
	end

	// ----------------------------------------
	// Input sync and activity LED
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
		// Single stage keeps the LED response short
		rxd_q <= uart_rxd_i;
	end

	// Reload while the line is low, then count the hold time out
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			rx_cnt <= '0;
		else if (!rxd_q)
			rx_cnt <= LED_W'(LED_HOLD_CYCLES);
		else if (rx_cnt != '0)
			rx_cnt <= rx_cnt - 1'b1;
	end

	assign led_o = {gpio_out, rx_cnt != '0};

endmodule

//--- verilog/soc_top.sv
// System controller top level
// Wishbone port into RAM, CSR bank and absent-device space, plus reset
`timescale 1ns/1ps

module soc_top #(
	parameter int RAM_ADDR_W = 8,
	parameter int DEBOUNCE_CYCLES = soc_ctrl_pkg::DEBOUNCE_CYCLES_DEF,
	parameter int PERIPH_HOLD_CYCLES = soc_ctrl_pkg::PERIPH_HOLD_CYCLES_DEF,
	parameter int LED_HOLD_CYCLES = soc_ctrl_pkg::LED_HOLD_CYCLES_DEF
) (
	input  logic sys_clk,
	input  logic reset_i,
	input  logic [soc_bus_pkg::WB_ADDR_W-1:0] wb_adr_i,
	input  logic [soc_bus_pkg::WB_DATA_W-1:0] wb_dat_i,
	output logic [soc_bus_pkg::WB_DATA_W-1:0] wb_dat_o,
	input  logic [soc_bus_pkg::WB_DATA_W/8-1:0] wb_sel_i,
	input  logic wb_we_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	output logic wb_ack_o,
	input  logic [soc_ctrl_pkg::GPIO_IN_W-1:0] dipsw_i,
	input  logic uart_rxd_i,
	output logic [soc_ctrl_pkg::GPIO_OUT_W:0] led_o,
	output logic periph_rst_n_o
);

	logic sys_rst;
	logic hard_reset;

	wb_if ram_bus ();
	wb_if csr_bus ();
	csr_if csr ();

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	reset_ctrl #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.PERIPH_HOLD_CYCLES(PERIPH_HOLD_CYCLES)
	) reset_ctrl_i (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.hard_reset_i(hard_reset),
		.sys_rst_o(sys_rst),
		.periph_rst_n_o(periph_rst_n_o)
	);

	// ----------------------------------------
	// Wishbone side
	// ----------------------------------------
	wb_decoder wb_decoder_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.adr_i(wb_adr_i),
		.dat_i(wb_dat_i),
		.sel_i(wb_sel_i),
		.we_i(wb_we_i),
		.cyc_i(wb_cyc_i),
		.stb_i(wb_stb_i),
		.dat_o(wb_dat_o),
		.ack_o(wb_ack_o),
		.ram_bus(ram_bus.master),
		.csr_bus(csr_bus.master)
	);

	scratch_ram #(
		.RAM_ADDR_W(RAM_ADDR_W)
	) scratch_ram_i (
		.sys_clk(sys_clk),
		.bus(ram_bus.slave)
	);

	csr_bridge csr_bridge_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.bus(csr_bus.slave),
		.csr(csr.bridge)
	);

	// Only CSR slave, its zero-when-unselected read covers other banks
	sys_ctrl #(
		.LED_HOLD_CYCLES(LED_HOLD_CYCLES)
	) sys_ctrl_i (
		.sys_clk(sys_clk),
		.sys_rst_i(sys_rst),
		.csr(csr.slave),
		.gpio_i(dipsw_i),
		.uart_rxd_i(uart_rxd_i),
		.led_o(led_o),
		.hard_reset_o(hard_reset)
	);

endmodule

//--- testbench/tb_clk_gen.sv
// Testbench clock source
// Free-running clock with a fixed period
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter real PERIOD_NS = 4.0
) (
	output logic clk_o
);

	initial clk_o = 1'b0;

	// Half period per toggle
	always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

//--- testbench/soc_tb.sv
// Testbench for the system controller
// Random Wishbone traffic and pin stimulus checked against a reference model
`timescale 1ns/1ps

module soc_tb;
	import soc_bus_pkg::*;
	import soc_ctrl_pkg::*;

	localparam int RAM_ADDR_W = 8;
	localparam int RAM_WORDS = 2**RAM_ADDR_W;
	localparam int DEBOUNCE_CYCLES = DEBOUNCE_CYCLES_DEF;
	localparam int PERIPH_HOLD_CYCLES = PERIPH_HOLD_CYCLES_DEF;
	localparam int LED_HOLD_CYCLES = LED_HOLD_CYCLES_DEF;
	localparam int RAM_OPS = 200;
	// CSR, GPIO, absent-region and hard-reset accesses
	localparam int OTHER_OPS = 64;
	// Long enough for an access stalled by a full reset window
	localparam int ACK_LIMIT = DEBOUNCE_CYCLES + 16;
	localparam int TIMEOUT_CYCLES = (RAM_WORDS + RAM_OPS + OTHER_OPS) * 20
		+ 3 * (DEBOUNCE_CYCLES + 8) + 2 * LED_HOLD_CYCLES + 64;

	logic sys_clk;
	logic reset_i;
	logic [WB_ADDR_W-1:0] wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	wb_sel_t wb_sel;
	logic wb_we;
	logic wb_cyc;
	logic wb_stb;
	logic wb_ack;
	logic [GPIO_IN_W-1:0] dipsw;
	logic uart_rxd;
	logic [GPIO_OUT_W:0] led;
	logic periph_rst_n;

	// Reference model state
	wb_data_t ram_model [RAM_WORDS];
	logic [GPIO_OUT_W-1:0] gpio_model;
	logic [GPIO_IN_W-1:0] dipsw_model;

	integer seed = 35;
	int cycle_count = 0;

	tb_clk_gen #(.PERIOD_NS(4.0)) clk_gen_i (.clk_o(sys_clk));

	soc_top #(
		.RAM_ADDR_W(RAM_ADDR_W),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.PERIPH_HOLD_CYCLES(PERIPH_HOLD_CYCLES),
		.LED_HOLD_CYCLES(LED_HOLD_CYCLES)
	) soc_top_i (
		.sys_clk(sys_clk),
		.reset_i(reset_i),
		.wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w),
		.wb_dat_o(wb_dat_r),
		.wb_sel_i(wb_sel),
		.wb_we_i(wb_we),
		.wb_cyc_i(wb_cyc),
		.wb_stb_i(wb_stb),
		.wb_ack_o(wb_ack),
		.dipsw_i(dipsw),
		.uart_rxd_i(uart_rxd),
		.led_o(led),
		.periph_rst_n_o(periph_rst_n)
	);

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// Word index wraps inside the RAM region
	function automatic logic [RAM_ADDR_W-1:0] ram_index(input logic [31:0] addr);
		return addr[RAM_ADDR_W+1:2];
	endfunction

	// CSR word address: bank over register index, upper offset bits ignored
	function automatic logic [31:0] csr_addr(input logic [3:0] bank,
		input logic [9:0] idx, input logic [12:0] upper);
		return {REGION_CSR, upper, bank, idx, 2'b00};
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			stop_on_error("data check failed");
		end
	endtask

	task automatic check_leds(input string name, input logic [2:0] exp,
		input logic [2:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			stop_on_error("LED check failed");
		end
	endtask

	// One Wishbone classic access, ack sampled on the falling edge
	task automatic bus_access(input logic [31:0] addr, input wb_data_t wdata,
		input wb_sel_t sel, input logic we, output wb_data_t rdata);
		int waited;
		@(posedge sys_clk);
		wb_adr <= addr;
		wb_dat_w <= wdata;
		wb_sel <= sel;
		wb_we <= we;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		waited = 0;
		@(negedge sys_clk);
		while (!wb_ack) begin
			waited++;
			if (waited > ACK_LIMIT)
				stop_on_error("no ack from the DUT within the access limit");
			@(negedge sys_clk);
		end
		rdata = wb_dat_r;
		// Drop the strobe in the cycle after ack
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic write_word(input logic [31:0] addr, input wb_data_t data,
		input wb_sel_t sel);
		wb_data_t unused;
		bus_access(addr, data, sel, 1'b1, unused);
	endtask

	task automatic read_word(input logic [31:0] addr, output wb_data_t data);
		bus_access(addr, '0, 4'hf, 1'b0, data);
	endtask

	// Byte-lane merge into the model RAM
	task automatic model_write(input logic [31:0] addr, input wb_data_t data,
		input wb_sel_t sel);
		for (int i = 0; i < 4; i++) begin
			if (sel[i])
				ram_model[ram_index(addr)][8*i +: 8] = data[8*i +: 8];
		end
	endtask

	// Run limit
	always @(posedge sys_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			stop_on_error("run exceeded its cycle limit");
	end

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		logic [31:0] r;
		logic [31:0] addr;
		wb_data_t data;
		wb_data_t rdata;
		wb_sel_t sel;
		logic [3:0] bank;
		logic [REGION_W-1:0] region;
		int waited;
		int hold;

		reset_i <= 1'b1;
		wb_adr <= '0;
		wb_dat_w <= '0;
		wb_sel <= '0;
		wb_we <= 1'b0;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		dipsw <= '0;
		uart_rxd <= 1'b1;
		gpio_model = '0;
		dipsw_model = '0;
		repeat (2) @(posedge sys_clk);
		reset_i <= 1'b0;

		// Fill the whole RAM, first access stalls until reset ends
		for (int i = 0; i < RAM_WORDS; i++) begin
			addr = 32'(i) << 2;
			data = rand32();
			write_word(addr, data, 4'hf);
			model_write(addr, data, 4'hf);
		end
		@(negedge sys_clk);
		check_leds("leds_after_reset", 3'b000, led);

		// RAM traffic with random lanes and wrapping offsets
		for (int n = 0; n < RAM_OPS; n++) begin
			r = rand32();
			addr = {REGION_RAM, r[28:2], 2'b00};
			if (r[31]) begin
				data = rand32();
				sel = wb_sel_t'(rand32());
				write_word(addr, data, sel);
				model_write(addr, data, sel);
			end else begin
				read_word(addr, rdata);
				check_data($sformatf("ram_read_%0d", n), ram_model[ram_index(addr)], rdata);
			end
		end

		// CSR reads
		r = rand32();
		read_word(csr_addr(SYSCTL_BANK, REG_SYSTEM_ID, r[12:0]), rdata);
		check_data("system_id", SYSTEM_ID, rdata);
		for (int n = 0; n < 4; n++) begin
			r = rand32();
			@(posedge sys_clk);
			dipsw <= r[3:0];
			dipsw_model = r[3:0];
			// Past the two-flop input sync
			repeat (4) @(posedge sys_clk);
			read_word(csr_addr(SYSCTL_BANK, REG_GPIO_IN, r[16:4]), rdata);
			check_data("gpio_in", {28'd0, dipsw_model}, rdata);
		end
		for (int n = 0; n < 4; n++) begin
			r = rand32();
			bank = r[3:0];
			if (bank == SYSCTL_BANK)
				bank = 4'd0;
			read_word(csr_addr(bank, r[13:4], r[26:14]), rdata);
			check_data("other_bank", '0, rdata);
		end

		// GPIO outputs
		for (int n = 0; n < 4; n++) begin
			data = rand32();
			write_word(csr_addr(SYSCTL_BANK, REG_GPIO_OUT, 13'd0), data, 4'hf);
			gpio_model = data[1:0];
			read_word(csr_addr(SYSCTL_BANK, REG_GPIO_OUT, 13'd0), rdata);
			check_data("gpio_out_readback", {30'd0, gpio_model}, rdata);
			@(negedge sys_clk);
			check_leds("gpio_out_leds", {gpio_model, 1'b0}, led);
		end

		// Absent regions, writes there must not reach the RAM
		for (int n = 0; n < 4; n++) begin
			r = rand32();
			region = r[31:29];
			if (region == REGION_RAM || region == REGION_CSR)
				region = region + 3'd1;
			addr = {region, r[28:2], 2'b00};
			read_word(addr, rdata);
			check_data("absent_read", ABSENT_PATTERN, rdata);
			write_word(addr, rand32(), 4'hf);
			addr = {REGION_RAM, r[28:2], 2'b00};
			read_word(addr, rdata);
			check_data("absent_write_ram", ram_model[ram_index(addr)], rdata);
		end

		// Hard reset clears GPIO, keeps the RAM
		data = rand32() | 32'd1;
		write_word(csr_addr(SYSCTL_BANK, REG_GPIO_OUT, 13'd0), data, 4'hf);
		gpio_model = data[1:0];
		write_word(csr_addr(SYSCTL_BANK, REG_HARD_RESET, 13'd0), rand32(), 4'hf);
		waited = 0;
		@(negedge sys_clk);
		while (periph_rst_n && waited < 4) begin
			waited++;
			@(negedge sys_clk);
		end
		if (periph_rst_n)
			stop_on_error("peripheral reset did not fall after a hard reset write");
		gpio_model = '0;
		read_word(csr_addr(SYSCTL_BANK, REG_GPIO_OUT, 13'd0), rdata);
		check_data("gpio_after_hard_reset", '0, rdata);
		@(negedge sys_clk);
		check_leds("leds_after_hard_reset", 3'b000, led);
		for (int n = 0; n < 8; n++) begin
			r = rand32();
			addr = {REGION_RAM, r[28:2], 2'b00};
			read_word(addr, rdata);
			check_data("ram_after_hard_reset", ram_model[ram_index(addr)], rdata);
		end

		// ----------------------------------------
		// Receive-activity LED
		// ----------------------------------------
		@(posedge sys_clk);
		uart_rxd <= 1'b0;
		waited = 0;
		@(negedge sys_clk);
		while (!led[0] && waited < 3) begin
			waited++;
			@(negedge sys_clk);
		end
		if (!led[0])
			stop_on_error("activity LED did not light within 3 cycles of a low pulse");
		check_leds("led_active", {gpio_model, 1'b1}, led);
		r = rand32();
		repeat (r[1:0]) @(posedge sys_clk);
		@(posedge sys_clk);
		uart_rxd <= 1'b1;
		// Count falling edges with the LED still lit
		hold = 0;
		@(negedge sys_clk);
		while (led[0] && hold <= LED_HOLD_CYCLES + 8) begin
			hold++;
			@(negedge sys_clk);
		end
		if (hold < LED_HOLD_CYCLES || hold > LED_HOLD_CYCLES + 4)
			stop_on_error($sformatf("activity LED stayed on %0d cycles after the line rose",
				hold));

		$display("all tests passed");
		$finish;
	end

endmodule

//--- soc_ctrl.f
verilog/soc_bus_pkg.sv
verilog/soc_ctrl_pkg.sv
verilog/soc_ifs.sv
verilog/reset_ctrl.sv
verilog/wb_decoder.sv
verilog/scratch_ram.sv
verilog/csr_bridge.sv
verilog/sys_ctrl.sv
verilog/soc_top.sv
testbench/tb_clk_gen.sv
testbench/soc_tb.sv

//--- Makefile
# Verilator build for the system controller testbench
# Override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP ?= soc_tb
FILELIST ?= soc_ctrl.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A failing check ends in $fatal, so the exit status carries the result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
